//--- all.f
verilog/ep0_pkg.sv
verilog/ep0_out_path.sv
verilog/ep0_in_path.sv
verilog/ep0_stage_ctrl.sv
verilog/ep0_request_decode.sv
verilog/ep0_usb.sv
verif/tb_ep0_usb.sv

//--- Makefile
TOOL     = verilator
FLAGS    = --binary --timing --assert -j 0
TOP      = tb_ep0_usb
FILELIST = all.f
BUILD    = obj_dir
LOG      = sim.log

.PHONY: sim clean

sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)
	./$(BUILD)/V$(TOP) | tee $(LOG)
	grep -q "Result: PASSED" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)

//--- verif/tb_ep0_usb.sv
// Table-driven testbench for the endpoint 0 control logic
`timescale 1ns/10ps
`default_nettype none

module tb_ep0_usb
  import ep0_pkg::*;
;

  localparam int BC_W  = 7;
  localparam int NROWS = 9;

  localparam logic [1:0] TM_NONE = 2'd0;
  localparam logic [1:0] TM_REQ  = 2'd1;
  localparam logic [1:0] TM_ERR  = 2'd2;
  localparam logic [1:0] TM_NAK  = 2'd3;

  // First SETUP byte on the wire sits in the top bits
  typedef struct packed {
    logic [63:0] wire_bytes;
    logic        hs;
    logic        ack;
    logic        addr;
    logic [1:0]  tm;
    logic        ds;
    logic        stall;
    fnaddr_t     fn;
  } row_t;

  logic            usbclk;
  logic            fiforst;
  usb_tok_t        tok;
  logic            wr;
  logic            rd;
  logic            txfall;
  logic            sendpckt;
  logic            clroutbsy;
  logic            clrinbsy;
  logic            setoutbsyreq;
  logic            setinbsyreq;
  logic            hsnak;
  logic            stall;
  logic            dstall;
  logic            sendstall;
  logic            usbreset;
  logic            discon;
  logic            hsmode;
  byte_t           outdatawr;
  logic [BC_W-1:0] upin0bc;
  setup_pkt_t      setupbuff;
  logic [BC_W-1:0] usbout0bc;
  logic            ep0busyout;
  logic            ep0nxtbusyout;
  logic            ep0busyin;
  logic            ep0stall;
  logic            ep0togglein;
  logic            ep0toggleout;
  logic            ep0datastage;
  logic            usboutbsyclr;
  logic            usbinbsyclr;
  logic            dvi;
  logic            setupack;
  logic            setaddr;
  logic            testmodereq;
  logic            testmodeerr;
  logic            testmodenak;
  logic            testmode;
  fnaddr_t         fnaddrusb;
  tmode_sel_t      testmodesel;

  row_t        rows [NROWS];
  string       names [NROWS];
  int          row_cnt;
  int          chk_cnt;
  int          err_cnt;
  string       cur_name;

  ep0_usb #(
    .BC_W (BC_W)
  ) i_dut (
    .usbclk        (usbclk),
    .fiforst       (fiforst),
    .tok           (tok),
    .wr            (wr),
    .rd            (rd),
    .txfall        (txfall),
    .sendpckt      (sendpckt),
    .clroutbsy     (clroutbsy),
    .clrinbsy      (clrinbsy),
    .setoutbsyreq  (setoutbsyreq),
    .setinbsyreq   (setinbsyreq),
    .hsnak         (hsnak),
    .stall         (stall),
    .dstall        (dstall),
    .sendstall     (sendstall),
    .usbreset      (usbreset),
    .discon        (discon),
    .hsmode        (hsmode),
    .outdatawr     (outdatawr),
    .upin0bc       (upin0bc),
    .setupbuff     (setupbuff),
    .usbout0bc     (usbout0bc),
    .ep0busyout    (ep0busyout),
    .ep0nxtbusyout (ep0nxtbusyout),
    .ep0busyin     (ep0busyin),
    .ep0stall      (ep0stall),
    .ep0togglein   (ep0togglein),
    .ep0toggleout  (ep0toggleout),
    .ep0datastage  (ep0datastage),
    .usboutbsyclr  (usboutbsyclr),
    .usbinbsyclr   (usbinbsyclr),
    .dvi           (dvi),
    .setupack      (setupack),
    .setaddr       (setaddr),
    .testmodereq   (testmodereq),
    .testmodeerr   (testmodeerr),
    .testmodenak   (testmodenak),
    .testmode      (testmode),
    .fnaddrusb     (fnaddrusb),
    .testmodesel   (testmodesel)
  );

  always #2 usbclk = ~usbclk;

  // Watchdog
  initial
  begin
    repeat (NROWS * 200) @(posedge usbclk);
    $display("timeout: tests did not finish within %0d cycles", NROWS * 200);
    $display("Result: FAILED");
    $finish;
  end

  // --------------------------------------------------
  // Helpers
  task automatic check_val(input string what, input logic [63:0] exp, input logic [63:0] act);
    chk_cnt++;
    if (act !== exp)
    begin
      err_cnt++;
      $display("mismatch %s %s: expected %0h actual %0h", cur_name, what, exp, act);
    end
  endtask

  function automatic setup_pkt_t wire_to_pkt(input logic [63:0] wb);
    setup_pkt_t p;
    p.bm_request_type = wb[63:56];
    p.b_request       = wb[55:48];
    p.w_value_lo      = wb[47:40];
    p.w_value_hi      = wb[39:32];
    p.w_index_lo      = wb[31:24];
    p.w_index_hi      = wb[23:16];
    p.w_length_lo     = wb[15:8];
    p.w_length_hi     = wb[7:0];
    return p;
  endfunction

  task automatic add_row(input string name, input logic [63:0] wb, input logic hs, ack, addr,
                         input logic [1:0] tm, input logic ds, st, input fnaddr_t fn);
    names[row_cnt]           = name;
    rows[row_cnt].wire_bytes = wb;
    rows[row_cnt].hs         = hs;
    rows[row_cnt].ack        = ack;
    rows[row_cnt].addr       = addr;
    rows[row_cnt].tm         = tm;
    rows[row_cnt].ds         = ds;
    rows[row_cnt].stall      = st;
    rows[row_cnt].fn         = fn;
    row_cnt++;
  endtask

  // --------------------------------------------------
  // Bus tasks
  task automatic send_setup(input row_t r);
    int i;
    @(negedge usbclk);
    tok.pid      = PID_SETUP;
    tok.settoken = 1'b1;
    for (i = 0; i < 8; i++)
    begin
      @(negedge usbclk);
      wr        = 1'b1;
      outdatawr = r.wire_bytes[63-8*i -: 8];
    end
    @(negedge usbclk);
    wr = 1'b0;
    #1;
    check_val("setupbuff", wire_to_pkt(r.wire_bytes), setupbuff);
    check_val("usbout0bc", 64'd8, 64'(usbout0bc));
    check_val("ep0toggleout before ack", 64'd0, 64'(ep0toggleout));
    check_val("ep0busyout during setup", 64'd1, 64'(ep0busyout));
    // Let the request flags settle
    @(negedge usbclk);
    @(negedge usbclk);
    clroutbsy = 1'b1;
    #1;
    check_val("setupack", 64'(r.ack), 64'(setupack));
    check_val("setaddr", 64'(r.addr), 64'(setaddr));
    check_val("testmodereq", 64'(r.tm == TM_REQ), 64'(testmodereq));
    check_val("testmodeerr", 64'(r.tm == TM_ERR), 64'(testmodeerr));
    check_val("testmodenak", 64'(r.tm == TM_NAK), 64'(testmodenak));
    check_val("usboutbsyclr on setup", 64'd0, 64'(usboutbsyclr));
    @(negedge usbclk);
    clroutbsy    = 1'b0;
    tok.settoken = 1'b0;
    #1;
    check_val("pulses after ack",
              64'd0, 64'({setupack, setaddr, testmodereq, testmodeerr, testmodenak}));
    check_val("ep0toggleout after ack", 64'd1, 64'(ep0toggleout));
    check_val("ep0busyout after ack", 64'd0, 64'(ep0busyout));
    check_val("ep0datastage", 64'(r.ds), 64'(ep0datastage));
    check_val("ep0stall", 64'(r.stall), 64'(ep0stall));
  endtask

  task automatic in_transfer();
    int   n;
    int   r;
    n = 2 + int'($urandom % 32'd63);
    @(negedge usbclk);
    tok.pid        = PID_IN;
    tok.tokrcvfall = 1'b1;
    setinbsyreq    = 1'b1;
    upin0bc        = BC_W'(n);
    @(negedge usbclk);
    tok.tokrcvfall = 1'b0;
    setinbsyreq    = 1'b0;
    #1;
    check_val("ep0busyin set", 64'd1, 64'(ep0busyin));
    // Data valid while bytes remain after the next read
    for (r = 0; r <= n; r++)
    begin
      @(negedge usbclk);
      rd = (r < n);
      #1;
      check_val($sformatf("dvi after %0d of %0d reads", r, n), 64'(r < n), 64'(dvi));
    end
    @(negedge usbclk);
    rd       = 1'b0;
    txfall   = 1'b1;
    sendpckt = 1'b1;
    @(negedge usbclk);
    txfall   = 1'b0;
    sendpckt = 1'b0;
    clrinbsy = 1'b1;
    #1;
    // First data packet after SETUP is DATA1
    check_val("ep0togglein before ack", 64'd1, 64'(ep0togglein));
    @(negedge usbclk);
    clrinbsy = 1'b0;
    #1;
    check_val("usbinbsyclr pulse", 64'd1, 64'(usbinbsyclr));
    check_val("ep0togglein after ack", 64'd0, 64'(ep0togglein));
    @(negedge usbclk);
    #1;
    check_val("ep0busyin clear", 64'd0, 64'(ep0busyin));
    check_val("usbinbsyclr end", 64'd0, 64'(usbinbsyclr));
  endtask

  task automatic out_token();
    @(negedge usbclk);
    tok.pid        = PID_OUT;
    tok.tokrcvfall = 1'b1;
    @(negedge usbclk);
    tok.tokrcvfall = 1'b0;
    #1;
    check_val("ep0datastage after out", 64'd0, 64'(ep0datastage));
    check_val("ep0nxtbusyout", 64'd1, 64'(ep0nxtbusyout));
    @(negedge usbclk);
    clroutbsy = 1'b1;
    #1;
    check_val("usboutbsyclr on out", 64'd1, 64'(usboutbsyclr));
    @(negedge usbclk);
    clroutbsy = 1'b0;
    tok.pid   = PID_SETUP;
  endtask

  task automatic status_in(input row_t r);
    logic [7:0] sel;
    sel = r.wire_bytes[23:16] - 8'd1;
    @(negedge usbclk);
    tok.pid        = PID_IN;
    tok.tokrcvfall = 1'b1;
    @(negedge usbclk);
    tok.tokrcvfall = 1'b0;
    txfall         = 1'b1;
    sendpckt       = 1'b1;
    @(negedge usbclk);
    txfall   = 1'b0;
    sendpckt = 1'b0;
    clrinbsy = 1'b1;
    #1;
    check_val("fnaddrusb", 64'(r.fn), 64'(fnaddrusb));
    check_val("ep0datastage in status", 64'd0, 64'(ep0datastage));
    @(negedge usbclk);
    clrinbsy = 1'b0;
    tok.pid  = PID_SETUP;
    #1;
    if (r.tm == TM_REQ)
    begin
      check_val("testmode", 64'd1, 64'(testmode));
      check_val("testmodesel", 64'(sel[1:0]), 64'(testmodesel));
    end
  endtask

  task automatic bus_reset();
    @(negedge usbclk);
    usbreset = 1'b1;
    @(negedge usbclk);
    usbreset = 1'b0;
    #1;
    check_val("fnaddrusb after reset", 64'd0, 64'(fnaddrusb));
  endtask

  // --------------------------------------------------
  // Main sequence
  initial
  begin
    int k;
    usbclk         = 1'b0;
    fiforst        = 1'b1;
    tok.pid        = PID_SETUP;
    tok.endp       = EP0_NUM;
    tok.tokrcvfall = 1'b0;
    tok.settoken   = 1'b0;
    wr             = 1'b0;
    rd             = 1'b0;
    txfall         = 1'b0;
    sendpckt       = 1'b0;
    clroutbsy      = 1'b0;
    clrinbsy       = 1'b0;
    setoutbsyreq   = 1'b0;
    setinbsyreq    = 1'b0;
    hsnak          = 1'b0;
    stall          = 1'b0;
    dstall         = 1'b0;
    sendstall      = 1'b0;
    usbreset       = 1'b0;
    discon         = 1'b0;
    hsmode         = 1'b1;
    outdatawr      = '0;
    upin0bc        = '0;
    row_cnt        = 0;
    chk_cnt        = 0;
    err_cnt        = 0;
    cur_name       = "reset";
    void'($urandom(32'h12aa));

    //      name              wire bytes             hs    ack   addr  tm       ds    stall fn
    add_row("set_address",    64'h0005_2a00_0000_0000, 1'b1, 1'b0, 1'b1, TM_NONE, 1'b0, 1'b0, 7'h2a);
    add_row("set_address_hi", 64'h0005_c500_0000_0000, 1'b1, 1'b0, 1'b1, TM_NONE, 1'b0, 1'b0, 7'h45);
    add_row("get_descriptor", 64'h8006_0001_0000_1200, 1'b1, 1'b1, 1'b0, TM_NONE, 1'b1, 1'b0, 7'h00);
    add_row("get_status",     64'h8000_0000_0000_0200, 1'b1, 1'b1, 1'b0, TM_NONE, 1'b1, 1'b0, 7'h00);
    add_row("set_config",     64'h0009_0100_0000_0000, 1'b1, 1'b1, 1'b0, TM_NONE, 1'b0, 1'b0, 7'h00);
    add_row("test_mode_j",    64'h0003_0200_0001_0000, 1'b1, 1'b0, 1'b0, TM_REQ,  1'b0, 1'b0, 7'h00);
    add_row("test_mode_pkt",  64'h0003_0200_0004_0000, 1'b1, 1'b0, 1'b0, TM_REQ,  1'b0, 1'b0, 7'h00);
    add_row("test_mode_fs",   64'h0003_0200_0002_0000, 1'b0, 1'b0, 1'b0, TM_ERR,  1'b0, 1'b1, 7'h00);
    add_row("test_mode_bad",  64'h0003_0200_0009_0000, 1'b1, 1'b0, 1'b0, TM_NAK,  1'b0, 1'b0, 7'h00);

    repeat (4) @(posedge usbclk);
    @(negedge usbclk);
    fiforst = 1'b0;

    for (k = 0; k < NROWS; k++)
    begin
      cur_name = names[k];
      @(negedge usbclk);
      hsmode = rows[k].hs;
      send_setup(rows[k]);
      if (rows[k].ds)
      begin
        in_transfer();
        out_token();
      end
      else
      begin
        status_in(rows[k]);
      end
      bus_reset();
    end

    $display("summary: %0d checks, %0d errors", chk_cnt, err_cnt);
    if (err_cnt == 0)
    begin
      $display("Result: PASSED");
    end
    else
    begin
      $display("Result: FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- verilog/ep0_usb.sv
// Endpoint 0 device control logic in the USB clock domain
`timescale 1ns/10ps
`default_nettype none

module ep0_usb
  import ep0_pkg::*;
#(
  parameter int BC_W = 7
)
(
  input  logic            usbclk,
  input  logic            fiforst,
  input  usb_tok_t        tok,
  input  logic            wr,
  input  logic            rd,
  input  logic            txfall,
  input  logic            sendpckt,
  input  logic            clroutbsy,
  input  logic            clrinbsy,
  input  logic            setoutbsyreq,
  input  logic            setinbsyreq,
  input  logic            hsnak,
  input  logic            stall,
  input  logic            dstall,
  input  logic            sendstall,
  input  logic            usbreset,
  input  logic            discon,
  input  logic            hsmode,
  input  byte_t           outdatawr,
  input  logic [BC_W-1:0] upin0bc,
  output setup_pkt_t      setupbuff,
  output logic [BC_W-1:0] usbout0bc,
  output logic            ep0busyout,
  output logic            ep0nxtbusyout,
  output logic            ep0busyin,
  output logic            ep0stall,
  output logic            ep0togglein,
  output logic            ep0toggleout,
  output logic            ep0datastage,
  output logic            usboutbsyclr,
  output logic            usbinbsyclr,
  output logic            dvi,
  output logic            setupack,
  output logic            setaddr,
  output logic            testmodereq,
  output logic            testmodeerr,
  output logic            testmodenak,
  output logic            testmode,
  output fnaddr_t         fnaddrusb,
  output tmode_sel_t      testmodesel
);

  logic       setup_start;
  logic       ep0_wr;
  logic       ep0_rd;
  logic       ep0_tx_end;
  logic       ep0_out_done;
  logic       ep0_in_done;
  logic       setup_done;
  logic       ep0_tok_end;
  logic       status_in_done;
  logic       dir_change;
  logic       out_bsy;
  logic       in_bsy;
  stage_e     stage;
  req_flags_t flags;

  ep0_out_path #(
    .BC_W (BC_W)
  ) i_out_path (
    .usbclk       (usbclk),
    .fiforst      (fiforst),
    .setup_start  (setup_start),
    .ep0_wr       (ep0_wr),
    .ep0_tok_end  (ep0_tok_end),
    .setup_done   (setup_done),
    .ep0_out_done (ep0_out_done),
    .setoutbsyreq (setoutbsyreq),
    .usbreset     (usbreset),
    .discon       (discon),
    .settoken     (tok.settoken),
    .outdatawr    (outdatawr),
    .setupbuff    (setupbuff),
    .usbout0bc    (usbout0bc),
    .out_bsy      (out_bsy)
  );

  ep0_in_path #(
    .BC_W (BC_W)
  ) i_in_path (
    .usbclk      (usbclk),
    .fiforst     (fiforst),
    .ep0_rd      (ep0_rd),
    .ep0_tx_end  (ep0_tx_end),
    .ep0_in_done (ep0_in_done),
    .setup_done  (setup_done),
    .setinbsyreq (setinbsyreq),
    .usbreset    (usbreset),
    .discon      (discon),
    .dir_change  (dir_change),
    .upin0bc     (upin0bc),
    .in_bsy      (in_bsy),
    .usbinbsyclr (usbinbsyclr),
    .dvi         (dvi)
  );

  ep0_stage_ctrl i_stage_ctrl (
    .usbclk         (usbclk),
    .fiforst        (fiforst),
    .tok            (tok),
    .wr             (wr),
    .rd             (rd),
    .txfall         (txfall),
    .clroutbsy      (clroutbsy),
    .clrinbsy       (clrinbsy),
    .hsnak          (hsnak),
    .stall          (stall),
    .dstall         (dstall),
    .sendstall      (sendstall),
    .usbreset       (usbreset),
    .discon         (discon),
    .out_bsy        (out_bsy),
    .in_bsy         (in_bsy),
    .pkt            (setupbuff),
    .flags          (flags),
    .setup_start    (setup_start),
    .ep0_wr         (ep0_wr),
    .ep0_rd         (ep0_rd),
    .ep0_tx_end     (ep0_tx_end),
    .ep0_out_done   (ep0_out_done),
    .ep0_in_done    (ep0_in_done),
    .setup_done     (setup_done),
    .ep0_tok_end    (ep0_tok_end),
    .status_in_done (status_in_done),
    .dir_change     (dir_change),
    .stage          (stage),
    .ep0busyout     (ep0busyout),
    .ep0nxtbusyout  (ep0nxtbusyout),
    .ep0busyin      (ep0busyin),
    .ep0stall       (ep0stall),
    .ep0togglein    (ep0togglein),
    .ep0toggleout   (ep0toggleout),
    .ep0datastage   (ep0datastage),
    .usboutbsyclr   (usboutbsyclr),
    .setupack       (setupack),
    .setaddr        (setaddr),
    .testmodereq    (testmodereq),
    .testmodeerr    (testmodeerr),
    .testmodenak    (testmodenak)
  );

  ep0_request_decode i_request_decode (
    .usbclk         (usbclk),
    .fiforst        (fiforst),
    .hsmode         (hsmode),
    .usbreset       (usbreset),
    .discon         (discon),
    .status_in_done (status_in_done),
    .ep0_tx_end     (ep0_tx_end),
    .sendpckt       (sendpckt),
    .stage          (stage),
    .pkt            (setupbuff),
    .flags          (flags),
    .fnaddrusb      (fnaddrusb),
    .testmode       (testmode),
    .testmodesel    (testmodesel)
  );

endmodule

`default_nettype wire

//--- verilog/ep0_request_decode.sv
// Standard request decode for SET_ADDRESS and SET_FEATURE TEST_MODE
`timescale 1ns/10ps
`default_nettype none

module ep0_request_decode
  import ep0_pkg::*;
(
  input  logic       usbclk,
  input  logic       fiforst,
  input  logic       hsmode,
  input  logic       usbreset,
  input  logic       discon,
  input  logic       status_in_done,
  input  logic       ep0_tx_end,
  input  logic       sendpckt,
  input  stage_e     stage,
  input  setup_pkt_t pkt,
  output req_flags_t flags,
  output fnaddr_t    fnaddrusb,
  output logic       testmode,
  output tmode_sel_t testmodesel
);

  logic is_std_dev;
  logic is_tm;
  logic sel_ok;

  // Standard request to the device
  assign is_std_dev = (pkt.bm_request_type == 8'h00);
  assign is_tm      = is_std_dev && (pkt.b_request == REQ_SET_FEATURE) &&
                      (pkt.w_value_lo == FEAT_TEST_MODE) && (pkt.w_value_hi == 8'h00);
  // Selectors 1 to 4 only
  assign sel_ok     = (pkt.w_index_hi >= 8'd1) && (pkt.w_index_hi <= 8'd4);

  always_ff @(posedge usbclk)
  begin
    if (fiforst)
    begin
      flags <= '0;
    end
    else
    begin
      flags.set_addr <= is_std_dev && (pkt.b_request == REQ_SET_ADDRESS);
      flags.tm_req   <= is_tm;
      flags.tm_err   <= is_tm && sel_ok && !hsmode;
      flags.tm_nak   <= is_tm && !sel_ok;
    end
  end

  // --------------------------------------------------
  // New address takes effect after the status packet
  always_ff @(posedge usbclk)
  begin
    if (fiforst || usbreset || discon)
    begin
      fnaddrusb <= '0;
    end
    else if (stage == STG_STATUS && ep0_tx_end && sendpckt && flags.set_addr)
    begin
      fnaddrusb <= pkt.w_value_lo[6:0];
    end
  end

  // Test mode starts once the status stage is acknowledged
  always_ff @(posedge usbclk)
  begin
    if (fiforst)
    begin
      testmode    <= 1'b0;
      testmodesel <= '0;
    end
    else if (status_in_done && flags.tm_req)
    begin
      testmode    <= sel_ok;
      testmodesel <= sel_ok ? pkt.w_index_hi[1:0] - 2'd1 : 2'd0;
    end
  end

  // Packet held while the status stage uses it
  a_pkt_held: assert property (@(posedge usbclk) disable iff (fiforst)
    (stage == STG_STATUS && (ep0_tx_end || status_in_done)) |-> $stable(pkt));

endmodule

`default_nettype wire

//--- verilog/ep0_stage_ctrl.sv
// Endpoint 0 control transfer stage, NAK and STALL state, toggles and request pulses
`timescale 1ns/10ps
`default_nettype none

module ep0_stage_ctrl
  import ep0_pkg::*;
(
  input  logic       usbclk,
  input  logic       fiforst,
  input  usb_tok_t   tok,
  input  logic       wr,
  input  logic       rd,
  input  logic       txfall,
  input  logic       clroutbsy,
  input  logic       clrinbsy,
  input  logic       hsnak,
  input  logic       stall,
  input  logic       dstall,
  input  logic       sendstall,
  input  logic       usbreset,
  input  logic       discon,
  input  logic       out_bsy,
  input  logic       in_bsy,
  input  setup_pkt_t pkt,
  input  req_flags_t flags,
  output logic       setup_start,
  output logic       ep0_wr,
  output logic       ep0_rd,
  output logic       ep0_tx_end,
  output logic       ep0_out_done,
  output logic       ep0_in_done,
  output logic       setup_done,
  output logic       ep0_tok_end,
  output logic       status_in_done,
  output logic       dir_change,
  output stage_e     stage,
  output logic       ep0busyout,
  output logic       ep0nxtbusyout,
  output logic       ep0busyin,
  output logic       ep0stall,
  output logic       ep0togglein,
  output logic       ep0toggleout,
  output logic       ep0datastage,
  output logic       usboutbsyclr,
  output logic       setupack,
  output logic       setaddr,
  output logic       testmodereq,
  output logic       testmodeerr,
  output logic       testmodenak
);

  logic ep0_sel;
  logic ep0_dir;
  logic settoken_q;
  logic hsnak_q;
  logic stall_q;
  logic cs_upd;
  logic nak_st;
  logic stall_st;

  // --------------------------------------------------
  // Endpoint 0 strobes
  assign ep0_sel        = (tok.endp == EP0_NUM);
  assign setup_start    = tok.settoken && !settoken_q;
  assign ep0_wr         = wr && ep0_sel;
  assign ep0_rd         = rd && ep0_sel;
  assign ep0_tx_end     = txfall && ep0_sel;
  assign ep0_out_done   = clroutbsy && ep0_sel && !tok.settoken;
  assign ep0_in_done    = clrinbsy && ep0_sel;
  assign setup_done     = clroutbsy && ep0_sel && tok.settoken;
  assign ep0_tok_end    = tok.tokrcvfall && ep0_sel &&
                          (tok.pid == PID_OUT || tok.pid == PID_SETUP);
  assign status_in_done = ep0_in_done && (stage == STG_STATUS);
  assign usboutbsyclr   = ep0_out_done;

  // Token goes against the direction of the transfer
  assign dir_change = ((tok.pid == PID_OUT || tok.pid == PID_PING) && ep0_dir) ||
                      (tok.pid == PID_IN && !ep0_dir);

  always_ff @(posedge usbclk)
  begin
    if (fiforst)
    begin
      settoken_q <= 1'b0;
      hsnak_q    <= 1'b0;
      stall_q    <= 1'b0;
    end
    else
    begin
      settoken_q <= tok.settoken;
      hsnak_q    <= hsnak;
      stall_q    <= stall;
    end
  end

  // --------------------------------------------------
  // Transfer stage and direction
  always_ff @(posedge usbclk)
  begin
    if (fiforst || usbreset || discon)
    begin
      stage   <= STG_IDLE;
      ep0_dir <= 1'b0;
    end
    else if (setup_done)
    begin
      if ({pkt.w_length_hi, pkt.w_length_lo} == 16'h0000)
      begin
        stage   <= STG_STATUS;
        ep0_dir <= 1'b0;
      end
      else
      begin
        stage   <= STG_DATA;
        ep0_dir <= pkt.bm_request_type[7];
      end
    end
    else if (stage == STG_DATA && tok.tokrcvfall && ep0_sel && dir_change)
    begin
      stage <= STG_STATUS;
    end
  end

  assign ep0datastage  = (stage == STG_DATA);
  assign ep0nxtbusyout = dir_change || (stage == STG_STATUS);

  // --------------------------------------------------
  // NAK and STALL response
  assign cs_upd = (hsnak != hsnak_q) || (stall != stall_q);

  always_ff @(posedge usbclk)
  begin
    if (fiforst)
    begin
      nak_st   <= 1'b0;
      stall_st <= 1'b0;
    end
    else if (cs_upd)
    begin
      nak_st   <= hsnak;
      stall_st <= stall;
    end
    else if (setup_done)
    begin
      if (flags.set_addr)
      begin
        nak_st   <= 1'b0;
        stall_st <= 1'b0;
      end
      else if (flags.tm_req)
      begin
        nak_st   <= flags.tm_err || flags.tm_nak;
        stall_st <= flags.tm_err;
      end
      else
      begin
        // Firmware answers other requests
        nak_st   <= 1'b1;
        stall_st <= 1'b0;
      end
    end
    else if (ep0datastage && sendstall)
    begin
      nak_st   <= 1'b1;
      stall_st <= dstall;
    end
  end

  assign ep0stall   = (ep0datastage && !dir_change) ? (stall_st || dstall) : stall_st;
  assign ep0busyout = dir_change ? !nak_st : out_bsy;
  assign ep0busyin  = dir_change ? !nak_st : in_bsy;

  // --------------------------------------------------
  // Data toggles
  always_ff @(posedge usbclk)
  begin
    if (fiforst || setup_start)
    begin
      ep0toggleout <= 1'b0;
    end
    else if (clroutbsy && ep0_sel)
    begin
      ep0toggleout <= (tok.settoken || !ep0datastage) ? 1'b1 : !ep0toggleout;
    end
  end

  always_ff @(posedge usbclk)
  begin
    if (fiforst)
    begin
      ep0togglein <= 1'b0;
    end
    else if (stage == STG_STATUS || tok.settoken)
    begin
      ep0togglein <= 1'b1;
    end
    else if (ep0_in_done)
    begin
      ep0togglein <= !ep0togglein;
    end
  end

  // Request pulses in the SETUP ACK cycle
  assign setaddr     = setup_done && flags.set_addr;
  assign setupack    = setup_done && !flags.set_addr && !flags.tm_req;
  assign testmodereq = setup_done && !flags.set_addr && flags.tm_req &&
                       !flags.tm_err && !flags.tm_nak;
  assign testmodeerr = setup_done && !flags.set_addr && flags.tm_req && flags.tm_err;
  assign testmodenak = setup_done && !flags.set_addr && flags.tm_req && flags.tm_nak;

  // Only a new SETUP reopens a data stage
  a_no_reopen: assert property (@(posedge usbclk) disable iff (fiforst)
    (stage == STG_STATUS && !setup_done) |=> (stage != STG_DATA));

endmodule

`default_nettype wire

//--- verilog/ep0_in_path.sv
// Endpoint 0 IN byte counter, IN busy flag and data valid for IN
`timescale 1ns/10ps
`default_nettype none

module ep0_in_path
  import ep0_pkg::*;
#(
  parameter int BC_W = 7
)
(
  input  logic            usbclk,
  input  logic            fiforst,
  input  logic            ep0_rd,
  input  logic            ep0_tx_end,
  input  logic            ep0_in_done,
  input  logic            setup_done,
  input  logic            setinbsyreq,
  input  logic            usbreset,
  input  logic            discon,
  input  logic            dir_change,
  input  logic [BC_W-1:0] upin0bc,
  output logic            in_bsy,
  output logic            usbinbsyclr,
  output logic            dvi
);

  logic [BC_W-1:0] in_bc;
  logic [BC_W-1:0] in_bc_nxt;
  logic [BC_W-1:0] up_bc;

  assign in_bc_nxt = ep0_rd ? in_bc + 1'b1 : in_bc;

  // Read count restarts at end of a packet
  always_ff @(posedge usbclk)
  begin
    if (fiforst || (ep0_tx_end && !ep0_rd))
    begin
      in_bc <= '0;
    end
    else
    begin
      in_bc <= in_bc_nxt;
    end
  end

  // Byte count loaded by the controller
  always_ff @(posedge usbclk)
  begin
    if (fiforst || usbinbsyclr)
    begin
      up_bc <= '0;
    end
    else if (setinbsyreq)
    begin
      up_bc <= upin0bc;
    end
  end

  // More data left once the next read count is short of the loaded count
  always_ff @(posedge usbclk)
  begin
    if (fiforst || dir_change)
    begin
      dvi <= 1'b0;
    end
    else
    begin
      dvi <= (in_bc_nxt < up_bc);
    end
  end

  // --------------------------------------------------
  // IN busy flag and its clear pulse
  always_ff @(posedge usbclk)
  begin
    if (fiforst || setup_done || usbreset || discon || (in_bsy && usbinbsyclr))
    begin
      in_bsy <= 1'b0;
    end
    else if (setinbsyreq)
    begin
      in_bsy <= 1'b1;
    end
  end

  always_ff @(posedge usbclk)
  begin
    if (fiforst)
    begin
      usbinbsyclr <= 1'b0;
    end
    else
    begin
      usbinbsyclr <= ep0_in_done;
    end
  end

endmodule

`default_nettype wire

//--- verilog/ep0_out_path.sv
// Endpoint 0 OUT byte counter with SETUP packet capture and OUT busy flag
`timescale 1ns/10ps
`default_nettype none

module ep0_out_path
  import ep0_pkg::*;
#(
  parameter int BC_W = 7
)
(
  input  logic            usbclk,
  input  logic            fiforst,
  input  logic            setup_start,
  input  logic            ep0_wr,
  input  logic            ep0_tok_end,
  input  logic            setup_done,
  input  logic            ep0_out_done,
  input  logic            setoutbsyreq,
  input  logic            usbreset,
  input  logic            discon,
  input  logic            settoken,
  input  byte_t           outdatawr,
  output setup_pkt_t      setupbuff,
  output logic [BC_W-1:0] usbout0bc,
  output logic            out_bsy
);

  // --------------------------------------------------
  // Received byte count
  always_ff @(posedge usbclk)
  begin
    if (fiforst || setup_start || (ep0_tok_end && out_bsy))
    begin
      usbout0bc <= '0;
    end
    else if (ep0_wr)
    begin
      usbout0bc <= usbout0bc + 1'b1;
    end
  end

  // SETUP byte goes to the slot picked by the count
  always_ff @(posedge usbclk)
  begin
    if (fiforst)
    begin
      setupbuff <= '0;
    end
    else if (ep0_wr && settoken)
    begin
      setupbuff[8*usbout0bc[2:0] +: 8] <= outdatawr;
    end
  end

  // --------------------------------------------------
  // OUT busy flag
  always_ff @(posedge usbclk)
  begin
    if (fiforst || setup_done || usbreset || discon || (out_bsy && ep0_out_done))
    begin
      out_bsy <= 1'b0;
    end
    else if (setoutbsyreq || setup_start)
    begin
      out_bsy <= 1'b1;
    end
  end

  // Host sends eight SETUP bytes at most
  a_setup_len: assert property (@(posedge usbclk) disable iff (fiforst)
    (ep0_wr && settoken) |-> (usbout0bc < BC_W'(8)));

endmodule

`default_nettype wire

//--- verilog/ep0_pkg.sv
// Shared types and constants for the USB endpoint 0 control logic
`default_nettype none

package ep0_pkg;

  typedef logic [7:0] byte_t;
  typedef logic [3:0] ep_num_t;
  typedef logic [6:0] fnaddr_t;
  // Standard test selector 1..4 kept as 0..3
  typedef logic [1:0] tmode_sel_t;

  localparam ep_num_t EP0_NUM = 4'h0;

  // Token PIDs, USB encoding
  typedef enum logic [3:0] {
    PID_OUT   = 4'b0001,
    PID_IN    = 4'b1001,
    PID_SETUP = 4'b1101,
    PID_PING  = 4'b0100
  } pid_e;

  // Control transfer stage
  typedef enum logic [1:0] {
    STG_IDLE   = 2'd0,
    STG_DATA   = 2'd1,
    STG_STATUS = 2'd2
  } stage_e;

  // --------------------------------------------------
  // Standard request codes
  localparam byte_t REQ_SET_ADDRESS = 8'h05;
  localparam byte_t REQ_SET_FEATURE = 8'h03;
  localparam byte_t FEAT_TEST_MODE  = 8'h02;

  // First byte on the wire sits in the low bits
  typedef struct packed {
    byte_t w_length_hi;
    byte_t w_length_lo;
    byte_t w_index_hi;
    byte_t w_index_lo;
    byte_t w_value_hi;
    byte_t w_value_lo;
    byte_t b_request;
    byte_t bm_request_type;
  } setup_pkt_t;

  typedef struct packed {
    pid_e    pid;
    ep_num_t endp;
    logic    tokrcvfall;
    logic    settoken;
  } usb_tok_t;

  typedef struct packed {
    logic set_addr;
    logic tm_req;
    logic tm_err;
    logic tm_nak;
  } req_flags_t;

endpackage

`default_nettype wire
